/* src/l2_defs.svh */
// Width and depth macros for the L2 store path, included by the package and every RTL module
`ifndef L2_DEFS_SVH
`define L2_DEFS_SVH

// Core store word and physical address
`define L2_WORD_W      32
`define L2_PADDR_W     32
`define L2_WORD_BYTES  (`L2_WORD_W / 8)

// Cache line built from core words
`define L2_LINE_WORDS  4
`define L2_LINE_W      (`L2_WORD_W * `L2_LINE_WORDS)
`define L2_LINE_BYTES  (`L2_LINE_W / 8)

// Request tags and write buffer depth
`define L2_TAG_W       2
`define L2_BUF_DEPTH   4

`endif

/* src/l2_pkg.sv */
// Shared struct and enum types of the store path, referenced as l2_pkg::name
`include "l2_defs.svh"

package l2_pkg;

    // L2 command code, the store path only ever sends WRITE
    typedef enum logic {
        WRITE = 1'b0,
        READ  = 1'b1
    } mem_cmd_t;

    // One buffered line, address is line aligned
    typedef struct packed {
        logic [`L2_PADDR_W-1:0]    addr;
        logic [`L2_LINE_W-1:0]     data;
        logic [`L2_LINE_BYTES-1:0] be;
    } line_entry_t;

    // ------------------------------
    // L2 request payload
    // ------------------------------
    typedef struct packed {
        mem_cmd_t                  cmd;
        logic [`L2_PADDR_W-1:0]    addr;
        logic [`L2_LINE_W-1:0]     data;
        logic [`L2_LINE_BYTES-1:0] byte_en;
    } l2_req_t;

    // Snoop answer, zero byte enable on a miss
    typedef struct packed {
        logic [`L2_LINE_W-1:0]     data;
        logic [`L2_LINE_BYTES-1:0] be;
    } snoop_resp_t;

endpackage

/* src/store_packer.sv */
// Store packer: merges core word stores into one open line and pushes finished lines
`timescale 1ns/1ps
`include "l2_defs.svh"

module store_packer (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_st_valid,
    input  logic [`L2_PADDR_W-1:0]      i_st_addr,
    input  logic [`L2_WORD_W-1:0]       i_st_data,
    input  logic [`L2_WORD_BYTES-1:0]   i_st_be,
    input  logic                        i_flush,
    input  logic                        i_buf_full,
    output logic                        o_push,
    output l2_pkg::line_entry_t         o_push_entry,
    output logic                        o_st_busy
);

    localparam int WORD_B = `L2_WORD_BYTES;
    localparam int BOFF_W = $clog2(WORD_B);
    localparam int IDX_W  = $clog2(`L2_LINE_WORDS);
    localparam int OFF_W  = BOFF_W + IDX_W;

    logic                   r_open;
    logic                   r_push;
    l2_pkg::line_entry_t    r_line;
    l2_pkg::line_entry_t    r_push_entry;

    logic                   w_st_accept;
    logic                   w_fl_accept;
    logic [`L2_PADDR_W-1:0] w_st_line;
    logic                   w_same_line;
    logic [IDX_W-1:0]       w_word_idx;
    l2_pkg::line_entry_t    w_merged;
    logic                   w_push_next;
    logic                   w_open_next;
    l2_pkg::line_entry_t    w_line_next;
    l2_pkg::line_entry_t    w_entry_next;

    // A pending push may fill the buffer, so hold the core off for it too
    assign o_st_busy    = i_buf_full || r_push;
    assign o_push       = r_push;
    assign o_push_entry = r_push_entry;

    assign w_st_accept = i_st_valid && !o_st_busy;
    assign w_fl_accept = i_flush && !o_st_busy;
    assign w_st_line   = {i_st_addr[`L2_PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign w_same_line = r_open && (r_line.addr == w_st_line);
    assign w_word_idx  = i_st_addr[BOFF_W +: IDX_W];

    // ------------------------------
    // Byte merge into the open line
    // ------------------------------
    always_comb begin
        w_merged      = w_same_line ? r_line : '0;
        w_merged.addr = w_st_line;
        for (int b = 0; b < WORD_B; b++) begin
            if (i_st_be[b]) begin
                w_merged.data[(w_word_idx * WORD_B + b) * 8 +: 8] = i_st_data[b * 8 +: 8];
                w_merged.be[w_word_idx * WORD_B + b]               = 1'b1;
            end
        end
    end

    // Flush rules
    always_comb begin
        w_push_next  = 1'b0;
        w_open_next  = r_open;
        w_line_next  = r_line;
        w_entry_next = r_push_entry;
        if (w_st_accept) begin
            w_line_next = w_merged;
            w_open_next = 1'b1;
            if (r_open && !w_same_line) begin
                // Old line goes out, the new one stays open
                w_push_next  = 1'b1;
                w_entry_next = r_line;
            end else if ((&w_merged.be) || w_fl_accept) begin
                w_push_next  = 1'b1;
                w_entry_next = w_merged;
                w_open_next  = 1'b0;
            end
        end else if (w_fl_accept && r_open) begin
            w_push_next  = 1'b1;
            w_entry_next = r_line;
            w_open_next  = 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_open <= 1'b0;
            r_push <= 1'b0;
        end else begin
            r_open <= w_open_next;
            r_push <= w_push_next;
        end
    end

    always_ff @(posedge i_clk) begin
        r_line       <= w_line_next;
        r_push_entry <= w_entry_next;
    end

    // Core honours busy, otherwise a store or flush would be dropped
    a_no_strobe_when_busy : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_st_busy |-> !(i_st_valid || i_flush)
    ) else $error("store packer strobed while busy");

endmodule

/* src/write_buffer.sv */
// Write buffer: four-entry FIFO of finished lines with a registered snoop lookup
`timescale 1ns/1ps
`include "l2_defs.svh"

module write_buffer (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_push,
    input  l2_pkg::line_entry_t     i_push_entry,
    input  logic                    i_pop,
    input  logic                    i_snoop_valid,
    input  logic [`L2_PADDR_W-1:0]  i_snoop_paddr,
    output logic                    o_full,
    output logic                    o_not_empty,
    output l2_pkg::line_entry_t     o_head,
    output logic                    o_snoop_valid,
    output l2_pkg::snoop_resp_t     o_snoop_resp
);

    localparam int DEPTH  = `L2_BUF_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int LINE_B = `L2_LINE_BYTES;
    localparam int OFF_W  = $clog2(LINE_B);

    l2_pkg::line_entry_t    r_mem [DEPTH];
    logic [PTR_W-1:0]       r_wr_ptr;
    logic [PTR_W-1:0]       r_rd_ptr;
    logic [PTR_W:0]         r_count;
    logic                   r_snoop_valid;
    l2_pkg::snoop_resp_t    r_snoop_resp;

    logic [`L2_PADDR_W-1:0] w_snoop_line;
    logic [PTR_W-1:0]       w_slot;
    l2_pkg::snoop_resp_t    w_snoop_merge;

    assign o_full        = (r_count == DEPTH[PTR_W:0]);
    assign o_not_empty   = (r_count != '0);
    assign o_head        = r_mem[r_rd_ptr];
    assign o_snoop_valid = r_snoop_valid;
    assign o_snoop_resp  = r_snoop_resp;

    // ------------------------------
    // FIFO pointers
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (i_push) r_wr_ptr <= r_wr_ptr + 1'b1;
            if (i_pop) r_rd_ptr <= r_rd_ptr + 1'b1;
            r_count <= r_count + {{PTR_W{1'b0}}, i_push} - {{PTR_W{1'b0}}, i_pop};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) r_mem[r_wr_ptr] <= i_push_entry;
    end

    // Walk from the head so younger bytes overwrite older ones
    assign w_snoop_line = {i_snoop_paddr[`L2_PADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    always_comb begin
        w_snoop_merge = '0;
        w_slot        = r_rd_ptr;
        for (int k = 0; k < DEPTH; k++) begin
            w_slot = r_rd_ptr + PTR_W'(k);
            if ((k < int'(r_count)) && (r_mem[w_slot].addr == w_snoop_line)) begin
                for (int b = 0; b < LINE_B; b++) begin
                    if (r_mem[w_slot].be[b]) begin
                        w_snoop_merge.data[b * 8 +: 8] = r_mem[w_slot].data[b * 8 +: 8];
                        w_snoop_merge.be[b]            = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) r_snoop_valid <= 1'b0;
        else r_snoop_valid <= i_snoop_valid;
    end

    always_ff @(posedge i_clk) begin
        r_snoop_resp <= w_snoop_merge;
    end

    a_no_push_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
    ) else $error("write buffer pushed while full");

    a_no_pop_empty : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> o_not_empty
    ) else $error("write buffer popped while empty");

endmodule

/* src/l2_req_issuer.sv */
// L2 request issuer: sends buffered lines as tagged write requests and retires tags on response
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_req_issuer (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_not_empty,
    input  l2_pkg::line_entry_t     i_head,
    input  logic                    i_l2_req_ready,
    input  logic                    i_l2_resp_valid,
    input  logic [`L2_TAG_W-1:0]    i_l2_resp_tag,
    output logic                    o_pop,
    output logic                    o_l2_req_valid,
    output l2_pkg::l2_req_t         o_l2_req,
    output logic [`L2_TAG_W-1:0]    o_l2_req_tag,
    output logic                    o_l2_resp_ready
);

    localparam int TAG_W = `L2_TAG_W;
    localparam int TAGS  = 1 << TAG_W;

    logic [TAGS-1:0]  r_tag_busy;
    logic [TAG_W-1:0] r_tag_ptr;
    logic             r_req_valid;
    l2_pkg::l2_req_t  r_req;
    logic [TAG_W-1:0] r_req_tag;

    logic             w_tag_found;
    logic [TAG_W-1:0] w_tag_sel;
    logic [TAG_W-1:0] w_cand;
    logic             w_load;
    logic             w_accept;
    logic             w_resp_fire;
    logic [TAGS-1:0]  w_set_mask;
    logic [TAGS-1:0]  w_clr_mask;

    assign o_l2_req_valid  = r_req_valid;
    assign o_l2_req        = r_req;
    assign o_l2_req_tag    = r_req_tag;
    assign o_l2_resp_ready = |r_tag_busy;

    // Entry leaves the buffer only once L2 has taken it
    assign w_accept    = r_req_valid && i_l2_req_ready;
    assign o_pop       = w_accept;
    assign w_load      = !r_req_valid && i_not_empty && w_tag_found;
    assign w_resp_fire = i_l2_resp_valid && o_l2_resp_ready;

    // ------------------------------
    // Rotating free tag search
    // ------------------------------
    always_comb begin
        w_tag_found = 1'b0;
        w_tag_sel   = r_tag_ptr;
        w_cand      = r_tag_ptr;
        for (int k = 0; k < TAGS; k++) begin
            w_cand = r_tag_ptr + TAG_W'(k);
            if (!w_tag_found && !r_tag_busy[w_cand]) begin
                w_tag_found = 1'b1;
                w_tag_sel   = w_cand;
            end
        end
    end

    assign w_set_mask = w_accept ? (TAGS'(1) << r_req_tag) : '0;
    assign w_clr_mask = w_resp_fire ? (TAGS'(1) << i_l2_resp_tag) : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_tag_busy  <= '0;
            r_tag_ptr   <= '0;
            r_req_valid <= 1'b0;
        end else begin
            r_tag_busy <= (r_tag_busy | w_set_mask) & ~w_clr_mask;
            if (w_load) begin
                r_req_valid <= 1'b1;
                r_tag_ptr   <= w_tag_sel + 1'b1;
            end else if (w_accept) begin
                r_req_valid <= 1'b0;
            end
        end
    end

    // Request payload, stable while waiting for ready
    always_ff @(posedge i_clk) begin
        if (w_load) begin
            r_req.cmd     <= l2_pkg::WRITE;
            r_req.addr    <= i_head.addr;
            r_req.data    <= i_head.data;
            r_req.byte_en <= i_head.be;
            r_req_tag     <= w_tag_sel;
        end
    end

    a_resp_tag_busy : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_l2_resp_valid |-> r_tag_busy[i_l2_resp_tag]
    ) else $error("L2 response for a tag that is not outstanding");

endmodule

/* src/l2_subsystem_wrapper.sv */
// Store path top level with flat core, snoop and L2 ports around packer, buffer and issuer
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_subsystem_wrapper (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // Core stores
    input  logic                        i_st_valid,
    input  logic [`L2_PADDR_W-1:0]      i_st_addr,
    input  logic [`L2_WORD_W-1:0]       i_st_data,
    input  logic [`L2_WORD_BYTES-1:0]   i_st_be,
    input  logic                        i_flush,
    output logic                        o_st_busy,

    // L2 request and response
    output logic                        o_l2_req_valid,
    output l2_pkg::mem_cmd_t            o_l2_req_cmd,
    output logic [`L2_PADDR_W-1:0]      o_l2_req_addr,
    output logic [`L2_TAG_W-1:0]        o_l2_req_tag,
    output logic [`L2_LINE_W-1:0]       o_l2_req_data,
    output logic [`L2_LINE_BYTES-1:0]   o_l2_req_byte_en,
    input  logic                        i_l2_req_ready,
    input  logic                        i_l2_resp_valid,
    input  logic [`L2_TAG_W-1:0]        i_l2_resp_tag,
    output logic                        o_l2_resp_ready,

    // Snoop
    input  logic                        i_snoop_req_valid,
    input  logic [`L2_PADDR_W-1:0]      i_snoop_req_paddr,
    output logic                        o_snoop_resp_valid,
    output logic [`L2_LINE_W-1:0]       o_snoop_resp_data,
    output logic [`L2_LINE_BYTES-1:0]   o_snoop_resp_be
);

    logic                w_push;
    l2_pkg::line_entry_t w_push_entry;
    logic                w_buf_full;
    logic                w_not_empty;
    l2_pkg::line_entry_t w_head;
    logic                w_pop;
    l2_pkg::l2_req_t     w_l2_req;
    l2_pkg::snoop_resp_t w_snoop_resp;

    // ------------------------------
    // Flat port split
    // ------------------------------
    assign o_l2_req_cmd      = w_l2_req.cmd;
    assign o_l2_req_addr     = w_l2_req.addr;
    assign o_l2_req_data     = w_l2_req.data;
    assign o_l2_req_byte_en  = w_l2_req.byte_en;
    assign o_snoop_resp_data = w_snoop_resp.data;
    assign o_snoop_resp_be   = w_snoop_resp.be;

    store_packer u_store_packer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_st_valid   (i_st_valid),
        .i_st_addr    (i_st_addr),
        .i_st_data    (i_st_data),
        .i_st_be      (i_st_be),
        .i_flush      (i_flush),
        .i_buf_full   (w_buf_full),
        .o_push       (w_push),
        .o_push_entry (w_push_entry),
        .o_st_busy    (o_st_busy)
    );

    write_buffer u_write_buffer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_push        (w_push),
        .i_push_entry  (w_push_entry),
        .i_pop         (w_pop),
        .i_snoop_valid (i_snoop_req_valid),
        .i_snoop_paddr (i_snoop_req_paddr),
        .o_full        (w_buf_full),
        .o_not_empty   (w_not_empty),
        .o_head        (w_head),
        .o_snoop_valid (o_snoop_resp_valid),
        .o_snoop_resp  (w_snoop_resp)
    );

    l2_req_issuer u_l2_req_issuer (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_not_empty     (w_not_empty),
        .i_head          (w_head),
        .i_l2_req_ready  (i_l2_req_ready),
        .i_l2_resp_valid (i_l2_resp_valid),
        .i_l2_resp_tag   (i_l2_resp_tag),
        .o_pop           (w_pop),
        .o_l2_req_valid  (o_l2_req_valid),
        .o_l2_req        (w_l2_req),
        .o_l2_req_tag    (o_l2_req_tag),
        .o_l2_resp_ready (o_l2_resp_ready)
    );

endmodule

/* verif/l2_checker.sv */
// Testbench monitor: compares accepted L2 requests and snoop answers with queued expectations
`timescale 1ns/1ps
`include "l2_defs.svh"

module l2_checker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_l2_req_valid,
    input  logic                        i_l2_req_ready,
    input  l2_pkg::mem_cmd_t            i_l2_req_cmd,
    input  logic [`L2_PADDR_W-1:0]      i_l2_req_addr,
    input  logic [`L2_TAG_W-1:0]        i_l2_req_tag,
    input  logic [`L2_LINE_W-1:0]       i_l2_req_data,
    input  logic [`L2_LINE_BYTES-1:0]   i_l2_req_byte_en,
    input  logic                        i_l2_resp_valid,
    input  logic [`L2_TAG_W-1:0]        i_l2_resp_tag,
    input  logic                        i_l2_resp_ready,
    input  logic                        i_snoop_req_valid,
    input  logic                        i_snoop_resp_valid,
    input  logic [`L2_LINE_W-1:0]       i_snoop_resp_data,
    input  logic [`L2_LINE_BYTES-1:0]   i_snoop_resp_be
);

    l2_pkg::l2_req_t        exp_req_q [$];
    logic [`L2_TAG_W-1:0]   exp_tag_q [$];
    l2_pkg::snoop_resp_t    exp_snoop_q [$];
    logic [(1 << `L2_TAG_W)-1:0] tag_out;
    logic                   snoop_pend;
    int                     err_count = 0;
    int                     accepted = 0;

    task automatic add_req(input logic [`L2_PADDR_W-1:0] addr, input logic [`L2_TAG_W-1:0] tag,
                           input logic [`L2_LINE_W-1:0] data,
                           input logic [`L2_LINE_BYTES-1:0] be);
        l2_pkg::l2_req_t r;
        r.cmd     = l2_pkg::WRITE;
        r.addr    = addr;
        r.data    = data;
        r.byte_en = be;
        exp_req_q.push_back(r);
        exp_tag_q.push_back(tag);
    endtask

    task automatic add_snoop(input logic [`L2_LINE_W-1:0] data,
                             input logic [`L2_LINE_BYTES-1:0] be);
        l2_pkg::snoop_resp_t s;
        s.data = data;
        s.be   = be;
        exp_snoop_q.push_back(s);
    endtask

    function automatic int pending_reqs();
        return exp_req_q.size();
    endfunction

    // ------------------------------
    // L2 request side
    // ------------------------------
    always @(posedge i_clk or negedge i_rst_n) begin : req_mon
        l2_pkg::l2_req_t              e;
        logic [`L2_TAG_W-1:0]         et;
        logic [(1 << `L2_TAG_W)-1:0]  tag_next;
        if (!i_rst_n) begin
            tag_out <= '0;
        end else begin
            tag_next = tag_out;
            if (i_l2_resp_ready != (|tag_out)) begin
                $display("FAILED at %0t: resp_ready %0b with outstanding tags %b",
                         $time, i_l2_resp_ready, tag_out);
                err_count++;
            end
            if (i_l2_req_valid && tag_out[i_l2_req_tag]) begin
                $display("FAILED at %0t: request uses outstanding tag %0d", $time, i_l2_req_tag);
                err_count++;
            end
            if (i_l2_req_valid && i_l2_req_ready) begin
                accepted++;
                tag_next[i_l2_req_tag] = 1'b1;
                if (exp_req_q.size() == 0) begin
                    $display("FAILED at %0t: unexpected request addr %h", $time, i_l2_req_addr);
                    err_count++;
                end else begin
                    e  = exp_req_q.pop_front();
                    et = exp_tag_q.pop_front();
                    if (i_l2_req_cmd != e.cmd || i_l2_req_addr != e.addr ||
                        i_l2_req_data != e.data || i_l2_req_byte_en != e.byte_en ||
                        i_l2_req_tag != et) begin
                        $display("FAILED at %0t: request addr %h tag %0d data %h be %h",
                                 $time, i_l2_req_addr, i_l2_req_tag, i_l2_req_data,
                                 i_l2_req_byte_en);
                        $display("FAILED at %0t: expected addr %h tag %0d data %h be %h",
                                 $time, e.addr, et, e.data, e.byte_en);
                        err_count++;
                    end
                end
            end
            if (i_l2_resp_valid && i_l2_resp_ready) begin
                tag_next[i_l2_resp_tag] = 1'b0;
            end
            tag_out <= tag_next;
        end
    end

    // ------------------------------
    // Snoop side
    // ------------------------------
    always @(posedge i_clk or negedge i_rst_n) begin : snoop_mon
        l2_pkg::snoop_resp_t s;
        if (!i_rst_n) begin
            snoop_pend <= 1'b0;
        end else begin
            snoop_pend <= i_snoop_req_valid;
            if (i_snoop_resp_valid != snoop_pend) begin
                $display("FAILED at %0t: snoop response valid %0b, one cycle after request %0b",
                         $time, i_snoop_resp_valid, snoop_pend);
                err_count++;
            end
            if (i_snoop_resp_valid) begin
                if (exp_snoop_q.size() == 0) begin
                    $display("FAILED at %0t: snoop response without expectation", $time);
                    err_count++;
                end else begin
                    s = exp_snoop_q.pop_front();
                    if (i_snoop_resp_data != s.data || i_snoop_resp_be != s.be) begin
                        $display("FAILED at %0t: snoop data %h be %h, expected %h be %h",
                                 $time, i_snoop_resp_data, i_snoop_resp_be, s.data, s.be);
                        err_count++;
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_l2_subsystem.sv */
// Testbench top for the store path: runs the operations of the stim file against the DUT
`timescale 1ns/1ps
`include "l2_defs.svh"

module tb_l2_subsystem;

    localparam int TIMEOUT_CYC = 300;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       st_valid;
    logic [`L2_PADDR_W-1:0]     st_addr;
    logic [`L2_WORD_W-1:0]      st_data;
    logic [`L2_WORD_BYTES-1:0]  st_be;
    logic                       flush;
    logic                       req_ready;
    logic                       resp_valid;
    logic [`L2_TAG_W-1:0]       resp_tag;
    logic                       snoop_valid;
    logic [`L2_PADDR_W-1:0]     snoop_paddr;

    logic                       st_busy;
    logic                       req_valid;
    l2_pkg::mem_cmd_t           req_cmd;
    logic [`L2_PADDR_W-1:0]     req_addr;
    logic [`L2_TAG_W-1:0]       req_tag;
    logic [`L2_LINE_W-1:0]      req_data;
    logic [`L2_LINE_BYTES-1:0]  req_be;
    logic                       resp_ready;
    logic                       snoop_resp_valid;
    logic [`L2_LINE_W-1:0]      snoop_data;
    logic [`L2_LINE_BYTES-1:0]  snoop_be;

    int tb_errors = 0;
    int timeouts  = 0;

    always #10 clk = ~clk;

    l2_subsystem_wrapper dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_st_valid(st_valid), .i_st_addr(st_addr), .i_st_data(st_data), .i_st_be(st_be),
        .i_flush(flush), .o_st_busy(st_busy),
        .o_l2_req_valid(req_valid), .o_l2_req_cmd(req_cmd), .o_l2_req_addr(req_addr),
        .o_l2_req_tag(req_tag), .o_l2_req_data(req_data), .o_l2_req_byte_en(req_be),
        .i_l2_req_ready(req_ready), .i_l2_resp_valid(resp_valid), .i_l2_resp_tag(resp_tag),
        .o_l2_resp_ready(resp_ready),
        .i_snoop_req_valid(snoop_valid), .i_snoop_req_paddr(snoop_paddr),
        .o_snoop_resp_valid(snoop_resp_valid), .o_snoop_resp_data(snoop_data),
        .o_snoop_resp_be(snoop_be)
    );

    l2_checker u_checker (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_l2_req_valid(req_valid), .i_l2_req_ready(req_ready), .i_l2_req_cmd(req_cmd),
        .i_l2_req_addr(req_addr), .i_l2_req_tag(req_tag), .i_l2_req_data(req_data),
        .i_l2_req_byte_en(req_be), .i_l2_resp_valid(resp_valid), .i_l2_resp_tag(resp_tag),
        .i_l2_resp_ready(resp_ready), .i_snoop_req_valid(snoop_valid),
        .i_snoop_resp_valid(snoop_resp_valid), .i_snoop_resp_data(snoop_data),
        .i_snoop_resp_be(snoop_be)
    );

    // ------------------------------
    // Operation tasks, all start on a falling edge
    // ------------------------------
    task automatic wait_not_busy();
        int n;
        n = 0;
        while (st_busy && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (st_busy) begin
            $display("Timeout at %0t: the store port stayed busy", $time);
            timeouts++;
        end
    endtask

    task automatic store_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        wait_not_busy();
        st_valid = 1'b1;
        st_addr  = a;
        st_data  = d;
        st_be    = be;
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic flush_line();
        wait_not_busy();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic snoop_line(input logic [31:0] a, input logic [127:0] d, input logic [15:0] be);
        // Let a pending push reach the buffer first
        repeat (2) @(negedge clk);
        u_checker.add_snoop(d, be);
        snoop_valid = 1'b1;
        snoop_paddr = a;
        @(negedge clk);
        snoop_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_resp(input logic [1:0] tag);
        int n;
        n = 0;
        while (!u_checker.tag_out[tag] && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (!u_checker.tag_out[tag]) begin
            $display("Timeout at %0t: tag %0d never became outstanding", $time, tag);
            timeouts++;
        end else begin
            resp_valid = 1'b1;
            resp_tag   = tag;
            @(negedge clk);
            resp_valid = 1'b0;
        end
    endtask

    task automatic wait_accepted(input int cnt);
        int n;
        n = 0;
        while (u_checker.accepted < cnt && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (u_checker.accepted < cnt) begin
            $display("Timeout at %0t: only %0d of %0d requests accepted",
                     $time, u_checker.accepted, cnt);
            timeouts++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((u_checker.pending_reqs() != 0 || req_valid || st_busy) && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (u_checker.pending_reqs() != 0 || req_valid || st_busy) begin
            $display("Timeout at %0t: the store path did not drain", $time);
            timeouts++;
        end
    endtask

    task automatic check_busy(input int level);
        repeat (2) @(negedge clk);
        if (st_busy != level[0]) begin
            $display("FAILED at %0t: o_st_busy is %0b, expected %0b", $time, st_busy, level[0]);
            tb_errors++;
        end
    endtask

    initial begin : main
        int           fd;
        string        line;
        logic [31:0]  a;
        logic [31:0]  d;
        logic [3:0]   wbe;
        logic [127:0] ld;
        logic [15:0]  lbe;
        logic [1:0]   tg;
        int           val;
        int           total;
        rst_n       = 1'b0;
        st_valid    = 1'b0;
        st_addr     = '0;
        st_data     = '0;
        st_be       = '0;
        flush       = 1'b0;
        req_ready   = 1'b0;
        resp_valid  = 1'b0;
        resp_tag    = '0;
        snoop_valid = 1'b0;
        snoop_paddr = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (req_valid || snoop_resp_valid || resp_ready || st_busy) begin
            $display("FAILED at %0t: outputs not low after reset", $time);
            tb_errors++;
        end

        fd = $fopen("verif/l2_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/l2_stim.txt");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
                case (line[0])
                    "S": begin
                        void'($sscanf(line, "S %h %h %h", a, d, wbe));
                        store_word(a, d, wbe);
                    end
                    "F": flush_line();
                    "R": begin
                        void'($sscanf(line, "R %d", val));
                        req_ready = (val != 0);
                    end
                    "Q": begin
                        void'($sscanf(line, "Q %h %h %h", a, ld, lbe));
                        snoop_line(a, ld, lbe);
                    end
                    "E": begin
                        void'($sscanf(line, "E %h %h %h %h", a, tg, ld, lbe));
                        u_checker.add_req(a, tg, ld, lbe);
                    end
                    "P": begin
                        void'($sscanf(line, "P %h", tg));
                        send_resp(tg);
                    end
                    "I": wait_idle();
                    "B": begin
                        void'($sscanf(line, "B %d", val));
                        check_busy(val);
                    end
                    "A": begin
                        void'($sscanf(line, "A %d", val));
                        wait_accepted(val);
                    end
                    default: begin
                        $display("Unknown operation in stimulus line: %s", line);
                        tb_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        if (u_checker.pending_reqs() != 0) begin
            $display("%0d expected requests never reached L2", u_checker.pending_reqs());
            tb_errors++;
        end
        total = u_checker.err_count + tb_errors + timeouts;
        $display("Errors: checker=%0d testbench=%0d timeouts=%0d",
                 u_checker.err_count, tb_errors, timeouts);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/l2_pkg.sv
src/store_packer.sv
src/write_buffer.sv
src/l2_req_issuer.sv
src/l2_subsystem_wrapper.sv
verif/l2_checker.sv
verif/tb_l2_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the store path testbench with Verilator, runs it and scans the log for failure
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_l2_subsystem \
    -f list.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Simulation log has no pass line"
    exit 1
fi
exit 0

/* verif/l2_stim.txt */
# Ops: S addr data be | F | R ready | Q addr exp_data exp_be | E addr tag data be
# P tag | I (wait idle) | B busy (expect o_st_busy) | A n (wait for n accepted requests)
R 1
E 00000100 0 00000000000033330000000011111111 030f
S 00000100 11111111 f
S 00000108 00003333 3
F
I
P 0
E 00000200 1 000000000000000000000000aaaaaaaa 000f
E 00000300 2 000000000000000000000000bbbbbbbb 000f
E 00000400 3 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0 ffff
S 00000200 aaaaaaaa f
S 00000300 bbbbbbbb f
S 00000400 c0c0c0c0 f
S 00000404 c1c1c1c1 f
S 00000408 c2c2c2c2 f
S 0000040c c3c3c3c3 f
I
P 1
P 2
P 3
R 0
E 00000500 0 00000000000000000000000011223344 000f
E 00000500 1 00000000000000009999999900007788 00f3
S 00000500 11223344 f
F
S 00000500 55667788 3
S 00000504 99999999 f
F
Q 00000500 00000000000000009999999911227788 00ff
Q 00000604 00000000000000000000000000000000 0000
E 00000700 2 00000000000000000000000077777777 000f
E 00000800 3 00000000000000000000000088888888 000f
S 00000700 77777777 f
F
S 00000800 88888888 f
F
B 1
R 1
E 00000900 0 00000000000000000000000099990000 000c
S 00000900 99990000 c
F
A 8
P 0
P 1
P 2
P 3
I
P 0
I
